// ==== verilog.f ====
sa_pkg.sv
sa_stream_if.sv
sa_data_input.sv
sa_pe_column.sv
sa_weight_top.sv
sa_top.sv
tb_sa_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log \
    && verilator --binary --timing --assert --top-module tb_sa_top \
        -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// ==== tb_sa_top.sv ====
// Testbench for the systolic array top with a dot-product reference queue
// and assertion-based checking of every result.

module tb_sa_top import sa_pkg::*; ();

    localparam int TIMEOUT = 2000;

    logic                  clk;
    logic                  reset_i;
    logic                  start_i;
    logic [1:0]            nth_conv_i;
    logic [4:0]            ofmap_size_i;
    logic                  wea_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [DATA_WIDTH-1:0] din_i;
    acc_t [COLS-1:0]       accu_data_o;
    logic                  accu_valid_o;
    logic                  conv_done_o;

    logic [DATA_WIDTH-1:0] act_mem [VEC_DEPTH][LANES];
    logic [DATA_WIDTH-1:0] wt_mem [WT_SETS][LANES][COLS];
    acc_t [COLS-1:0]       exp_q [$];
    acc_t [COLS-1:0]       exp_word;
    logic                  prev_valid;
    int                    errors;
    int                    result_cnt;
    int                    done_cnt;
    int                    tests_run;
    int                    tests_failed;
    int                    err_mark;

    sa_top UUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .nth_conv_i   (nth_conv_i),
        .ofmap_size_i (ofmap_size_i),
        .wea_i        (wea_i),
        .addr_i       (addr_i),
        .din_i        (din_i),
        .accu_data_o  (accu_data_o),
        .accu_valid_o (accu_valid_o),
        .conv_done_o  (conv_done_o)
    );

    always #4 clk = ~clk;

    ////////////////////
    // Result checking
    ////////////////////

    always @(negedge clk) begin
        if (!reset_i) begin
            if (accu_valid_o) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("[FAIL] %0t: result with no expected vector", $time);
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    for (int c = 0; c < COLS; c++) begin
                        assert (accu_data_o[c] == exp_word[c]) else begin
                            errors++;
                            $display("[FAIL] %0t: column %0d got %h, expected %h",
                                     $time, c, accu_data_o[c], exp_word[c]);
                        end
                    end
                end
                result_cnt++;
            end
            // Results of one run leave back to back.
            assert (!(prev_valid && !accu_valid_o && exp_q.size() > 0)) else begin
                errors++;
                $display("[FAIL] %0t: gap between consecutive results", $time);
            end
            if (conv_done_o) begin
                done_cnt++;
            end
            prev_valid = accu_valid_o;
        end
    end

    a_done_after_last: assert property (@(posedge clk) disable iff (reset_i)
        conv_done_o |-> $past(accu_valid_o) && !accu_valid_o)
        else begin
            errors++;
            $display("[FAIL] %0t: conv_done_o not right after the last result", $time);
        end

    a_done_single: assert property (@(posedge clk) disable iff (reset_i)
        conv_done_o |=> !conv_done_o)
        else begin
            errors++;
            $display("[FAIL] %0t: conv_done_o longer than one cycle", $time);
        end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input logic [1:0] bank, input int offset,
                              input logic [DATA_WIDTH-1:0] data);
        wea_i  = 1'b1;
        addr_i = {bank, OFFSET_WIDTH'(offset)};
        din_i  = data;
        step();
        wea_i  = 1'b0;
    endtask

    // Activation bytes are drawn from lo up to 255.
    task automatic fill_activations(input int lo);
        logic [DATA_WIDTH-1:0] data;
        for (int r = 0; r < VEC_DEPTH; r++) begin
            for (int k = 0; k < LANES; k++) begin
                data = DATA_WIDTH'(lo + int'($urandom % (256 - lo)));
                act_mem[r][k] = data;
                write_byte(BANK_DATA, r * LANES + k, data);
            end
        end
    endtask

    task automatic write_weight(input int set, input int k, input int c,
                                input logic [DATA_WIDTH-1:0] data);
        wt_mem[set][k][c] = data;
        write_byte(BANK_WEIGHT, set * LANES * COLS + k * COLS + c, data);
    endtask

    function automatic void push_expected(input int set, input int last_row);
        acc_t [COLS-1:0] word;
        int              sum;
        for (int r = 0; r <= last_row; r++) begin
            for (int c = 0; c < COLS; c++) begin
                sum = 0;
                for (int k = 0; k < LANES; k++) begin
                    sum += int'(act_mem[r][k]) * int'($signed(wt_mem[set][k][c]));
                end
                word[c] = ACC_WIDTH'(sum);
            end
            exp_q.push_back(word);
        end
    endfunction

    // One run; busy_start adds start pulses during LOAD and RUN.
    task automatic run_conv(input int set, input int size, input bit busy_start);
        int done_before;
        int res_before;
        int cycles;
        done_before = done_cnt;
        res_before  = result_cnt;
        push_expected(set, size);
        nth_conv_i   = 2'(set);
        ofmap_size_i = 5'(size);
        start_i      = 1'b1;
        step();
        start_i = 1'b0;
        if (busy_start) begin
            repeat (4) step();
            nth_conv_i = 2'(set + 1);
            start_i    = 1'b1;
            step();
            start_i = 1'b0;
            repeat (12) step();
            start_i = 1'b1;
            step();
            start_i = 1'b0;
        end
        cycles = 0;
        while (done_cnt == done_before && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (done_cnt == done_before) begin
            errors++;
            $display("Timeout: conv_done_o did not arrive within %0d cycles", TIMEOUT);
            exp_q.delete();
        end
        repeat (10) step();
        assert (result_cnt - res_before == size + 1) else begin
            errors++;
            $display("[FAIL] %0t: %0d results, expected %0d", $time,
                     result_cnt - res_before, size + 1);
        end
        assert (done_cnt - done_before == 1) else begin
            errors++;
            $display("[FAIL] %0t: %0d done pulses, expected 1", $time,
                     done_cnt - done_before);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("[test] %s: failed", name);
        end else begin
            $display("[test] %s: passed", name);
        end
        err_mark = errors;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        start_i      = 1'b0;
        nth_conv_i   = '0;
        ofmap_size_i = '0;
        wea_i        = 1'b0;
        addr_i       = '0;
        din_i        = '0;
        prev_valid   = 1'b0;
        errors       = 0;
        result_cnt   = 0;
        done_cnt     = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        void'($urandom(42));

        repeat (10) step();
        reset_i = 1'b0;

        repeat (20) step();
        assert (result_cnt == 0 && done_cnt == 0) else begin
            errors++;
            $display("[FAIL] %0t: output activity without a start", $time);
        end
        report_test("idle after reset");

        fill_activations(0);
        for (int s = 0; s < WT_SETS; s++) begin
            for (int k = 0; k < LANES; k++) begin
                for (int c = 0; c < COLS; c++) begin
                    write_weight(s, k, c, DATA_WIDTH'($urandom));
                end
            end
        end
        run_conv(0, 7, 1'b0);
        report_test("weight set 0, 8 vectors");

        for (int s = 1; s < WT_SETS; s++) begin
            run_conv(s, 7, 1'b0);
        end
        report_test("weight sets 1 to 3");

        // Large activations with extreme weights push every sum past 16 bits.
        fill_activations(192);
        for (int k = 0; k < LANES; k++) begin
            for (int c = 0; c < COLS; c++) begin
                write_weight(0, k, c, (c < COLS / 2) ? 8'd127 : 8'd128);
            end
        end
        run_conv(0, 31, 1'b0);
        report_test("full buffer with wrap");

        for (int i = 0; i < WT_SETS * LANES * COLS; i++) begin
            write_byte(2'b10, i, DATA_WIDTH'($urandom));
            write_byte(2'b11, i, DATA_WIDTH'($urandom));
        end
        run_conv(1, 7, 1'b1);
        report_test("unused banks and busy start");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sa_top.sv ====
// Systolic array top: write bank decode, activation streamer and weight array.

module sa_top import sa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  logic [1:0]            nth_conv_i,
    input  logic [4:0]            ofmap_size_i,
    input  logic                  wea_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0] din_i,
    output acc_t [COLS-1:0]       accu_data_o,
    output logic                  accu_valid_o,
    output logic                  conv_done_o
);

    sa_bank_e                bank;
    logic [OFFSET_WIDTH-1:0] offset;
    logic                    data_wea;
    logic                    wt_wea;
    logic                    weight_ready;

    // Unused bank codes fall through with no write.
    assign bank     = sa_bank_e'(addr_i[ADDR_WIDTH-1:OFFSET_WIDTH]);
    assign offset   = addr_i[OFFSET_WIDTH-1:0];
    assign data_wea = wea_i && (bank == BANK_DATA);
    assign wt_wea   = wea_i && (bank == BANK_WEIGHT);

    sa_stream_if #(.LANES(LANES)) act_stream ();

    sa_data_input #(
        .LANES (LANES)
    ) u_data_input (
        .clk            (clk),
        .reset_i        (reset_i),
        .wea_i          (data_wea),
        .addr_i         (offset),
        .din_i          (din_i),
        .ofmap_size_i   (ofmap_size_i),
        .weight_ready_i (weight_ready),
        .stream         (act_stream.source)
    );

    sa_weight_top #(
        .LANES (LANES),
        .COLS  (COLS)
    ) u_weight_top (
        .clk            (clk),
        .reset_i        (reset_i),
        .start_i        (start_i),
        .nth_conv_i     (nth_conv_i),
        .wea_i          (wt_wea),
        .addr_i         (offset),
        .din_i          (din_i),
        .stream         (act_stream.sink),
        .weight_ready_o (weight_ready),
        .accu_data_o    (accu_data_o),
        .accu_valid_o   (accu_valid_o),
        .conv_done_o    (conv_done_o)
    );

endmodule

// ==== sa_weight_top.sv ====
// Weight buffer, weight load FSM, input skew and the array of PE columns.
// Runs one convolution pass per start strobe.

module sa_weight_top import sa_pkg::*; #(
    parameter int LANES = 4,
    parameter int COLS  = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  logic [1:0]              nth_conv_i,
    input  logic                    wea_i,
    input  logic [OFFSET_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]   din_i,
    sa_stream_if.sink               stream,
    output logic                    weight_ready_o,
    output acc_t [COLS-1:0]         accu_data_o,
    output logic                    accu_valid_o,
    output logic                    conv_done_o
);

    localparam int SET_SIZE   = LANES * COLS;
    localparam int WADDR_BITS = $clog2(WT_SETS * SET_SIZE);
    localparam int STG_BITS   = $clog2(SET_SIZE);
    localparam int CNT_BITS   = $clog2(SET_SIZE + LANES + 1);

    wt_state_e                           state_q;
    logic [CNT_BITS-1:0]                 cnt_q;
    logic [1:0]                          nth_q;
    logic                                weight_load_q;
    logic [WADDR_BITS-1:0]               rd_addr;
    logic [DATA_WIDTH-1:0]               wmem [WT_SETS * SET_SIZE];
    logic [SET_SIZE-1:0][DATA_WIDTH-1:0] stage_q;
    logic [LANES-1:0][DATA_WIDTH-1:0]    in_vec_q;
    logic                                in_valid_q;
    logic [LANES-1:0][DATA_WIDTH-1:0]    skew_vec;
    logic [COLS-1:0]                     col_valid;

    // Set-major layout: set, then lane, then column.
    always_ff @(posedge clk) begin
        if (wea_i && (int'(addr_i) < WT_SETS * SET_SIZE)) begin
            wmem[WADDR_BITS'(addr_i)] <= din_i;
        end
    end

    assign rd_addr = WADDR_BITS'(int'(nth_q) * SET_SIZE + int'(cnt_q));

    always_ff @(posedge clk) begin
        if (state_q == WT_LOAD) begin
            stage_q[cnt_q[STG_BITS-1:0]] <= wmem[rd_addr];
        end
    end

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q       <= WT_IDLE;
            cnt_q         <= '0;
            nth_q         <= '0;
            weight_load_q <= 1'b0;
        end else begin
            weight_load_q <= (state_q == WT_LOAD) && (cnt_q == CNT_BITS'(SET_SIZE - 1));
            unique case (state_q)
                WT_IDLE: begin
                    if (start_i) begin
                        state_q <= WT_LOAD;
                        cnt_q   <= '0;
                        nth_q   <= nth_conv_i;
                    end
                end
                WT_LOAD: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_BITS'(SET_SIZE - 1)) begin
                        state_q <= WT_RUN;
                        cnt_q   <= '0;
                    end
                end
                WT_RUN: begin
                    if (stream.done) begin
                        state_q <= WT_DRAIN;
                        cnt_q   <= '0;
                    end
                end
                WT_DRAIN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_BITS'(LANES)) begin
                        state_q <= WT_IDLE;
                    end
                end
                default: state_q <= WT_IDLE;
            endcase
        end
    end

    assign weight_ready_o = (state_q == WT_RUN);
    assign conv_done_o    = (state_q == WT_DRAIN) && (cnt_q == CNT_BITS'(LANES));

    ////////////////////
    // Input skew
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= stream.valid;
        end
    end

    always_ff @(posedge clk) begin
        in_vec_q <= stream.vec;
    end

    // Lane k is delayed k cycles so it meets stage k of each column.
    for (genvar k = 0; k < LANES; k++) begin : g_skew
        if (k == 0) begin : g_direct
            assign skew_vec[0] = in_vec_q[0];
        end else begin : g_delay
            logic [k-1:0][DATA_WIDTH-1:0] dly_q;

            always_ff @(posedge clk) begin
                dly_q[0] <= in_vec_q[k];
                for (int i = 1; i < k; i++) begin
                    dly_q[i] <= dly_q[i-1];
                end
            end

            assign skew_vec[k] = dly_q[k-1];
        end
    end

    for (genvar c = 0; c < COLS; c++) begin : g_col
        logic [LANES-1:0][DATA_WIDTH-1:0] col_wt;

        for (genvar k = 0; k < LANES; k++) begin : g_wt
            assign col_wt[k] = stage_q[k * COLS + c];
        end

        sa_pe_column #(
            .LANES (LANES)
        ) u_col (
            .clk           (clk),
            .reset_i       (reset_i),
            .weight_load_i (weight_load_q),
            .weight_i      (col_wt),
            .act_i         (skew_vec),
            .act_valid_i   (in_valid_q),
            .sum_o         (accu_data_o[c]),
            .sum_valid_o   (col_valid[c])
        );
    end

    assign accu_valid_o = &col_valid;

    a_valid_in_run: assert property (@(posedge clk) disable iff (reset_i)
        stream.valid |-> state_q == WT_RUN)
        else $error("Activation vector arrived outside RUN");

endmodule

// ==== sa_pe_column.sv ====
// One systolic column: a chain of multiply-accumulate stages holding
// stationary signed weights.

module sa_pe_column import sa_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             weight_load_i,
    input  logic [LANES-1:0][DATA_WIDTH-1:0] weight_i,
    input  logic [LANES-1:0][DATA_WIDTH-1:0] act_i,
    input  logic                             act_valid_i,
    output acc_t                             sum_o,
    output logic                             sum_valid_o
);

    logic signed [DATA_WIDTH-1:0] w_q [LANES];
    acc_t                         psum_q [LANES];
    logic [LANES-1:0]             valid_q;

    always_ff @(posedge clk) begin
        if (weight_load_i) begin
            for (int k = 0; k < LANES; k++) begin
                w_q[k] <= $signed(weight_i[k]);
            end
        end
    end

    // Stage k adds lane k, which arrives k cycles after lane 0.
    for (genvar k = 0; k < LANES; k++) begin : g_stage
        logic signed [ACC_WIDTH-1:0] prod;

        assign prod = $signed({1'b0, act_i[k]}) * w_q[k];

        if (k == 0) begin : g_first
            always_ff @(posedge clk) begin
                psum_q[0] <= prod;
            end
        end else begin : g_next
            always_ff @(posedge clk) begin
                psum_q[k] <= psum_q[k-1] + prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LANES-2:0], act_valid_i};
        end
    end

    assign sum_o       = psum_q[LANES-1];
    assign sum_valid_o = valid_q[LANES-1];

    a_load_when_empty: assert property (@(posedge clk) disable iff (reset_i)
        weight_load_i |-> !act_valid_i && (valid_q == '0))
        else $error("Weights replaced while vectors are in the column");

endmodule

// ==== sa_data_input.sv ====
// Activation buffer in per-lane banks and the sequencer that streams
// one vector per cycle once the weights are in place.

module sa_data_input import sa_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    wea_i,
    input  logic [OFFSET_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]   din_i,
    input  logic [4:0]              ofmap_size_i,
    input  logic                    weight_ready_i,
    sa_stream_if.source             stream
);

    localparam int LANE_BITS = $clog2(LANES);
    localparam int ROW_BITS  = $clog2(VEC_DEPTH);

    data_state_e                      state_q;
    logic [ROW_BITS-1:0]              row_q;
    logic [ROW_BITS-1:0]              count_q;
    logic                             ready_q;
    logic                             wr_en;
    logic [LANE_BITS-1:0]             wr_lane;
    logic [ROW_BITS-1:0]              wr_row;
    logic [LANES-1:0][DATA_WIDTH-1:0] rd_vec;

    // Low offset bits pick the lane bank, the rest pick the row.
    assign wr_en   = wea_i && (int'(addr_i) < VEC_DEPTH * LANES);
    assign wr_lane = addr_i[LANE_BITS-1:0];
    assign wr_row  = ROW_BITS'(addr_i >> LANE_BITS);

    for (genvar k = 0; k < LANES; k++) begin : g_bank
        logic [DATA_WIDTH-1:0] mem [VEC_DEPTH];
        logic [DATA_WIDTH-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (wr_en && wr_lane == LANE_BITS'(k)) begin
                mem[wr_row] <= din_i;
            end
            if (state_q == DATA_STREAM) begin
                rd_q <= mem[row_q];
            end
        end

        assign rd_vec[k] = rd_q;
    end

    assign stream.vec = rd_vec;

    ////////////////////
    // Stream sequencer
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= DATA_IDLE;
            row_q        <= '0;
            count_q      <= '0;
            ready_q      <= 1'b0;
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            stream.done  <= 1'b0;
        end else begin
            ready_q      <= weight_ready_i;
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
            // Done follows the final vector by one cycle.
            stream.done  <= stream.last;
            unique case (state_q)
                DATA_IDLE: begin
                    if (weight_ready_i && !ready_q) begin
                        state_q <= DATA_STREAM;
                        row_q   <= '0;
                        count_q <= ofmap_size_i;
                    end
                end
                DATA_STREAM: begin
                    stream.valid <= 1'b1;
                    stream.last  <= (row_q == count_q);
                    row_q        <= row_q + 1'b1;
                    if (row_q == count_q) begin
                        state_q <= DATA_IDLE;
                    end
                end
                default: state_q <= DATA_IDLE;
            endcase
        end
    end

    a_valid_needs_ready: assert property (@(posedge clk) disable iff (reset_i)
        $rose(stream.valid) |-> weight_ready_i)
        else $error("Activation stream started without loaded weights");

    // The weights must stay loaded up to the final vector.
    a_last_with_valid: assert property (@(posedge clk) disable iff (reset_i)
        stream.last |-> stream.valid && weight_ready_i)
        else $error("Stream last seen without valid or loaded weights");

endmodule

// ==== sa_stream_if.sv ====
// Activation vector stream from the data buffer to the systolic array.

interface sa_stream_if import sa_pkg::*; #(
    parameter int LANES = 4
) ();

    logic [LANES-1:0][DATA_WIDTH-1:0] vec;
    logic                             valid;
    logic                             last;
    logic                             done;

    // No back-pressure, so the sink only observes.
    modport source (
        output vec, valid, last, done
    );

    modport sink (
        input vec, valid, last, done
    );

endinterface

// ==== sa_pkg.sv ====
// Shared sizes, write bank codes, FSM state types and the accumulator word.

package sa_pkg;

    ////////////////////
    // Array sizes
    ////////////////////

    localparam int LANES      = 4;
    localparam int COLS       = 4;
    localparam int DATA_WIDTH = 8;
    localparam int ACC_WIDTH  = 16;
    localparam int VEC_DEPTH  = 32;
    localparam int WT_SETS    = 4;

    ////////////////////
    // Write addressing
    ////////////////////

    // Top two address bits select the bank.
    localparam int ADDR_WIDTH   = 10;
    localparam int OFFSET_WIDTH = ADDR_WIDTH - 2;

    typedef enum logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] {
        BANK_DATA   = 2'b00,
        BANK_WEIGHT = 2'b01
    } sa_bank_e;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [ACC_WIDTH-1:0] acc_t;

    typedef enum logic {
        DATA_IDLE,
        DATA_STREAM
    } data_state_e;

    typedef enum logic [1:0] {
        WT_IDLE,
        WT_LOAD,
        WT_RUN,
        WT_DRAIN
    } wt_state_e;

endpackage
